// File: hw/soc_periph_pkg.sv
/*
 * shared definitions for the peripheral subsystem
 *  - APB and event vector widths with their vector types
 *  - block address map and register word offsets
 *  - fabric-controller event bit positions
 *  - register request and response structs, APB FSM states
 */

package soc_periph_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    localparam int APB_ADDR_W = 32;
    localparam int APB_DATA_W = 32;
    localparam int FC_EVENT_W = 32;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;
    typedef logic [FC_EVENT_W-1:0] fc_events_t;

    //////////////////////////////
    // address map
    //////////////////////////////
    // address bits 11..8 pick the block, bits 3..2 the word inside it
    localparam int BLK_SEL_LSB = 8;
    localparam int BLK_SEL_MSB = 11;
    localparam int OFS_LSB     = 2;
    localparam int OFS_MSB     = 3;

    typedef logic [BLK_SEL_MSB-BLK_SEL_LSB:0] blk_code_t;
    typedef logic [OFS_MSB-OFS_LSB:0]         reg_ofs_t;

    localparam blk_code_t BLK_TIMER = 4'h0;
    localparam blk_code_t BLK_WDT   = 4'h1;
    localparam blk_code_t BLK_EVENT = 4'h2;

    // timer words
    localparam reg_ofs_t TMR_CNT  = 2'd0;
    localparam reg_ofs_t TMR_CMP  = 2'd1;
    localparam reg_ofs_t TMR_CTRL = 2'd2;

    // watchdog words
    localparam reg_ofs_t WDT_LOAD  = 2'd0;
    localparam reg_ofs_t WDT_CTRL  = 2'd1;
    localparam reg_ofs_t WDT_KICK  = 2'd2;
    localparam reg_ofs_t WDT_COUNT = 2'd3;

    // event block words
    localparam reg_ofs_t EVT_MASK = 2'd0;

    // fc event positions, non-Ibex layout
    localparam int FC_EV_DMA_PE   = 8;
    localparam int FC_EV_TIMER_LO = 10;
    localparam int FC_EV_PF       = 12;
    localparam int FC_EV_REF_EDGE = 14;

    //////////////////////////////
    // register port types
    //////////////////////////////
    typedef struct packed {
        logic      wr;
        logic      rd;
        reg_ofs_t  ofs;
        apb_data_t wdata;
    } reg_req_t;

    typedef struct packed {
        apb_data_t rdata;
        logic      err;
    } reg_rsp_t;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_ACCESS,
        APB_RESP
    } apb_state_e;

endpackage

// File: hw/apb_access_fsm.sv
/*
 * APB slave front end
 *  - three-state FSM (idle, access, response) with one wait state
 *  - captures address, write data and direction in the setup phase
 *  - issues a single register strobe and returns the decoded response
 */

`timescale 1ns/1ps

module apb_access_fsm (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  soc_periph_pkg::apb_addr_t paddr_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    output soc_periph_pkg::reg_req_t  req_o,
    output soc_periph_pkg::apb_addr_t blk_addr_o,
    input  soc_periph_pkg::reg_rsp_t  rsp_i,
    output soc_periph_pkg::apb_data_t prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o
);

    import soc_periph_pkg::*;

    apb_state_e state_q;
    apb_state_e state_d;
    apb_addr_t  addr_q;
    apb_data_t  wdata_q;
    logic       write_q;

    // setup phase is psel without penable
    always_comb begin
        state_d = state_q;
        case (state_q)
            APB_IDLE: begin
                if (psel_i && !penable_i) begin
                    state_d = APB_ACCESS;
                end
            end
            APB_ACCESS: state_d = APB_RESP;
            APB_RESP:   state_d = APB_IDLE;
            default:    state_d = APB_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= APB_IDLE;
            write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == APB_IDLE && state_d == APB_ACCESS) begin
                write_q <= pwrite_i;
            end
        end
    end

    // transfer payload
    always_ff @(posedge clk_i) begin
        if (state_q == APB_IDLE && state_d == APB_ACCESS) begin
            addr_q  <= paddr_i;
            wdata_q <= pwdata_i;
        end
    end

    //////////////////////////////
    // register side
    //////////////////////////////
    // strobes live only in the access cycle
    assign req_o.wr    = (state_q == APB_ACCESS) && write_q;
    assign req_o.rd    = (state_q == APB_ACCESS) && !write_q;
    assign req_o.ofs   = addr_q[OFS_MSB:OFS_LSB];
    assign req_o.wdata = wdata_q;
    assign blk_addr_o  = addr_q;

    //////////////////////////////
    // APB response
    //////////////////////////////
    assign pready_o  = (state_q == APB_RESP);
    assign prdata_o  = (state_q == APB_RESP) ? rsp_i.rdata : '0;
    assign pslverr_o = (state_q == APB_RESP) && rsp_i.err;

endmodule

// File: hw/periph_decoder.sv
/*
 * block decoder for the register strobe
 *  - one-hot block selects from address bits 11..8
 *  - read data mux over the three blocks
 *  - registered response with error on unmapped blocks
 */

`timescale 1ns/1ps

module periph_decoder (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  soc_periph_pkg::reg_req_t  req_i,
    input  soc_periph_pkg::apb_addr_t blk_addr_i,
    output logic                     tmr_sel_o,
    output logic                     wdt_sel_o,
    output logic                     evt_sel_o,
    output soc_periph_pkg::reg_req_t  req_o,
    input  soc_periph_pkg::apb_data_t tmr_rdata_i,
    input  soc_periph_pkg::apb_data_t wdt_rdata_i,
    input  soc_periph_pkg::apb_data_t evt_rdata_i,
    output soc_periph_pkg::reg_rsp_t  rsp_o
);

    import soc_periph_pkg::*;

    blk_code_t blk_code;
    logic      strobe;
    logic      unmapped;
    apb_data_t rdata_mux;
    reg_rsp_t  rsp_q;

    assign blk_code = blk_addr_i[BLK_SEL_MSB:BLK_SEL_LSB];
    assign strobe   = req_i.wr || req_i.rd;

    // selects only fire together with a strobe
    assign tmr_sel_o = strobe && (blk_code == BLK_TIMER);
    assign wdt_sel_o = strobe && (blk_code == BLK_WDT);
    assign evt_sel_o = strobe && (blk_code == BLK_EVENT);
    assign unmapped  = !(blk_code inside {BLK_TIMER, BLK_WDT, BLK_EVENT});

    // every block sees the same request, its select decides
    assign req_o = req_i;

    always_comb begin
        case (blk_code)
            BLK_TIMER: rdata_mux = tmr_rdata_i;
            BLK_WDT:   rdata_mux = wdt_rdata_i;
            BLK_EVENT: rdata_mux = evt_rdata_i;
            default:   rdata_mux = '0;
        endcase
    end

    //////////////////////////////
    // response register
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_q <= '0;
        end else if (strobe) begin
            rsp_q.rdata <= req_i.rd ? rdata_mux : '0;
            rsp_q.err   <= unmapped;
        end
    end

    assign rsp_o = rsp_q;

endmodule

// File: hw/timer_unit.sv
/*
 * compare timer
 *  - free running 32-bit count with enable
 *  - compare register with optional clear on match
 *  - one-cycle low interrupt strobe on match
 */

`timescale 1ns/1ps

module timer_unit (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     sel_i,
    input  soc_periph_pkg::reg_req_t  req_i,
    output soc_periph_pkg::apb_data_t rdata_o,
    output logic                     irq_lo_o
);

    import soc_periph_pkg::*;

    apb_data_t  cnt_q;
    apb_data_t  cmp_q;
    logic [1:0] ctrl_q;
    logic       irq_lo_q;
    logic       wr_cnt;
    logic       wr_cmp;
    logic       wr_ctrl;
    logic       match;

    assign wr_cnt  = sel_i && req_i.wr && (req_i.ofs == TMR_CNT);
    assign wr_cmp  = sel_i && req_i.wr && (req_i.ofs == TMR_CMP);
    assign wr_ctrl = sel_i && req_i.wr && (req_i.ofs == TMR_CTRL);

    // ctrl bit 0 enables, bit 1 clears the count on match
    assign match = ctrl_q[0] && (cnt_q == cmp_q);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cmp_q  <= '0;
            ctrl_q <= '0;
        end else begin
            if (wr_cmp) begin
                cmp_q <= req_i.wdata;
            end
            if (wr_ctrl) begin
                ctrl_q <= req_i.wdata[1:0];
            end
        end
    end

    // a software write wins over counting
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q    <= '0;
            irq_lo_q <= 1'b0;
        end else begin
            irq_lo_q <= match;
            if (wr_cnt) begin
                cnt_q <= req_i.wdata;
            end else if (match && ctrl_q[1]) begin
                cnt_q <= '0;
            end else if (ctrl_q[0]) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (req_i.ofs)
            TMR_CNT:  rdata_o = cnt_q;
            TMR_CMP:  rdata_o = cmp_q;
            TMR_CTRL: rdata_o = {{(APB_DATA_W-2){1'b0}}, ctrl_q};
            default:  rdata_o = '0;
        endcase
    end

    assign irq_lo_o = irq_lo_q;

endmodule

// File: hw/wdt_unit.sv
/*
 * watchdog
 *  - load value, enable and kick registers
 *  - down-counter reloaded on enable and on kick
 *  - sticky reset request once the count expires
 */

`timescale 1ns/1ps

module wdt_unit (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     sel_i,
    input  soc_periph_pkg::reg_req_t  req_i,
    output soc_periph_pkg::apb_data_t rdata_o,
    output logic                     wdt_reset_o
);

    import soc_periph_pkg::*;

    apb_data_t load_q;
    apb_data_t cnt_q;
    logic      en_q;
    logic      expired_q;
    logic      wr_load;
    logic      wr_ctrl;
    logic      wr_kick;
    logic      reload;

    assign wr_load = sel_i && req_i.wr && (req_i.ofs == WDT_LOAD);
    assign wr_ctrl = sel_i && req_i.wr && (req_i.ofs == WDT_CTRL);
    assign wr_kick = sel_i && req_i.wr && (req_i.ofs == WDT_KICK);

    // enabling also restarts from the load value
    assign reload = wr_kick || (wr_ctrl && req_i.wdata[0]);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            load_q <= '0;
            en_q   <= 1'b0;
        end else begin
            if (wr_load) begin
                load_q <= req_i.wdata;
            end
            if (wr_ctrl) begin
                en_q <= req_i.wdata[0];
            end
        end
    end

    //////////////////////////////
    // countdown and expiry
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q     <= '0;
            expired_q <= 1'b0;
        end else begin
            if (reload) begin
                cnt_q <= load_q;
            end else if (en_q && cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
            // stays set until the next system reset
            if (en_q && cnt_q == '0) begin
                expired_q <= 1'b1;
            end
        end
    end

    always_comb begin
        case (req_i.ofs)
            WDT_LOAD:  rdata_o = load_q;
            WDT_CTRL:  rdata_o = {{(APB_DATA_W-1){1'b0}}, en_q};
            WDT_COUNT: rdata_o = cnt_q;
            default:   rdata_o = '0;
        endcase
    end

    assign wdt_reset_o = expired_q;

endmodule

// File: hw/fc_event_map.sv
/*
 * fabric-controller event vector
 *  - two-flop synchronizer and both-edge detect on slow_clk_i
 *  - event mask register
 *  - registered, masked fc_events_o at the fixed bit positions
 */

`timescale 1ns/1ps

module fc_event_map (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      sel_i,
    input  soc_periph_pkg::reg_req_t   req_i,
    output soc_periph_pkg::apb_data_t  rdata_o,
    input  logic                      timer_lo_i,
    input  logic                      dma_pe_evt_i,
    input  logic                      pf_evt_i,
    input  logic                      slow_clk_i,
    output soc_periph_pkg::fc_events_t fc_events_o
);

    import soc_periph_pkg::*;

    logic [1:0] slow_sync_q;
    logic       slow_prev_q;
    logic       ref_edge;
    apb_data_t  mask_q;
    fc_events_t ev_raw;
    fc_events_t events_q;

    //////////////////////////////
    // slow clock edge detect
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            slow_sync_q <= '0;
            slow_prev_q <= 1'b0;
        end else begin
            slow_sync_q <= {slow_sync_q[0], slow_clk_i};
            slow_prev_q <= slow_sync_q[1];
        end
    end

    // rise and fall share one event
    assign ref_edge = slow_sync_q[1] ^ slow_prev_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mask_q <= '0;
        end else if (sel_i && req_i.wr && req_i.ofs == EVT_MASK) begin
            mask_q <= req_i.wdata;
        end
    end

    always_comb begin
        ev_raw                 = '0;
        ev_raw[FC_EV_DMA_PE]   = dma_pe_evt_i;
        ev_raw[FC_EV_TIMER_LO] = timer_lo_i;
        ev_raw[FC_EV_PF]       = pf_evt_i;
        ev_raw[FC_EV_REF_EDGE] = ref_edge;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            events_q <= '0;
        end else begin
            events_q <= ev_raw & mask_q;
        end
    end

    assign rdata_o     = (req_i.ofs == EVT_MASK) ? mask_q : '0;
    assign fc_events_o = events_q;

endmodule

// File: hw/soc_periph_top.sv
/*
 * peripheral subsystem top level
 *  - APB front end and block decoder
 *  - timer, watchdog and fc event map
 */

`timescale 1ns/1ps

module soc_periph_top (
    input  logic                      clk_i,
    input  logic                      reset_i,
    // APB slave port
    input  soc_periph_pkg::apb_addr_t  paddr_i,
    input  soc_periph_pkg::apb_data_t  pwdata_i,
    input  logic                      pwrite_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    output soc_periph_pkg::apb_data_t  prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    // event sources
    input  logic                      dma_pe_evt_i,
    input  logic                      pf_evt_i,
    input  logic                      slow_clk_i,
    output soc_periph_pkg::fc_events_t fc_events_o,
    output logic                      wdt_reset_o
);

    import soc_periph_pkg::*;

    reg_req_t  fsm_req;
    reg_req_t  blk_req;
    reg_rsp_t  dec_rsp;
    apb_addr_t blk_addr;
    logic      tmr_sel;
    logic      wdt_sel;
    logic      evt_sel;
    apb_data_t tmr_rdata;
    apb_data_t wdt_rdata;
    apb_data_t evt_rdata;
    logic      timer_lo_evt;

    //////////////////////////////
    // bus front end
    //////////////////////////////
    apb_access_fsm u_apb_fsm (
        .clk_i      ( clk_i     ),
        .reset_i    ( reset_i   ),
        .psel_i     ( psel_i    ),
        .penable_i  ( penable_i ),
        .pwrite_i   ( pwrite_i  ),
        .paddr_i    ( paddr_i   ),
        .pwdata_i   ( pwdata_i  ),
        .req_o      ( fsm_req   ),
        .blk_addr_o ( blk_addr  ),
        .rsp_i      ( dec_rsp   ),
        .prdata_o   ( prdata_o  ),
        .pready_o   ( pready_o  ),
        .pslverr_o  ( pslverr_o )
    );

    periph_decoder u_decoder (
        .clk_i       ( clk_i     ),
        .reset_i     ( reset_i   ),
        .req_i       ( fsm_req   ),
        .blk_addr_i  ( blk_addr  ),
        .tmr_sel_o   ( tmr_sel   ),
        .wdt_sel_o   ( wdt_sel   ),
        .evt_sel_o   ( evt_sel   ),
        .req_o       ( blk_req   ),
        .tmr_rdata_i ( tmr_rdata ),
        .wdt_rdata_i ( wdt_rdata ),
        .evt_rdata_i ( evt_rdata ),
        .rsp_o       ( dec_rsp   )
    );

    //////////////////////////////
    // register blocks
    //////////////////////////////
    timer_unit u_timer (
        .clk_i    ( clk_i        ),
        .reset_i  ( reset_i      ),
        .sel_i    ( tmr_sel      ),
        .req_i    ( blk_req      ),
        .rdata_o  ( tmr_rdata    ),
        .irq_lo_o ( timer_lo_evt )
    );

    wdt_unit u_wdt (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .sel_i       ( wdt_sel     ),
        .req_i       ( blk_req     ),
        .rdata_o     ( wdt_rdata   ),
        .wdt_reset_o ( wdt_reset_o )
    );

    fc_event_map u_fc_events (
        .clk_i        ( clk_i        ),
        .reset_i      ( reset_i      ),
        .sel_i        ( evt_sel      ),
        .req_i        ( blk_req      ),
        .rdata_o      ( evt_rdata    ),
        .timer_lo_i   ( timer_lo_evt ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .pf_evt_i     ( pf_evt_i     ),
        .slow_clk_i   ( slow_clk_i   ),
        .fc_events_o  ( fc_events_o  )
    );

endmodule

// File: verification/tb_soc_periph.sv
/*
 * directed testbench for the APB peripheral subsystem
 *  - clock, reset and a cycle limit for the whole run
 *  - APB read and write tasks and a value compare task
 *  - tests for register readback, unmapped access, timer period,
 *    fc event mask and watchdog expiry
 */

`timescale 1ns/1ps

module tb_soc_periph;

    import soc_periph_pkg::*;

    localparam int MAX_CYCLES   = 2000;
    localparam int PREADY_LIMIT = 8;

    logic       clk_i;
    logic       reset_i;
    apb_addr_t  paddr_i;
    apb_data_t  pwdata_i;
    logic       pwrite_i;
    logic       psel_i;
    logic       penable_i;
    apb_data_t  prdata_o;
    logic       pready_o;
    logic       pslverr_o;
    logic       dma_pe_evt_i;
    logic       pf_evt_i;
    logic       slow_clk_i;
    fc_events_t fc_events_o;
    logic       wdt_reset_o;

    int         error_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;
    integer     seed;
    apb_data_t  cmp_val;
    apb_data_t  load_val;
    apb_data_t  mask_val;

    soc_periph_top u_dut (
        .clk_i        ( clk_i        ),
        .reset_i      ( reset_i      ),
        .paddr_i      ( paddr_i      ),
        .pwdata_i     ( pwdata_i     ),
        .pwrite_i     ( pwrite_i     ),
        .psel_i       ( psel_i       ),
        .penable_i    ( penable_i    ),
        .prdata_o     ( prdata_o     ),
        .pready_o     ( pready_o     ),
        .pslverr_o    ( pslverr_o    ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .pf_evt_i     ( pf_evt_i     ),
        .slow_clk_i   ( slow_clk_i   ),
        .fc_events_o  ( fc_events_o  ),
        .wdt_reset_o  ( wdt_reset_o  )
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // run limit set well above the sum of all test lengths
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("ERROR: run exceeded %0d cycles without finishing", MAX_CYCLES);
            $display("checks: %0d  errors: %0d", check_count, error_count + 1);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("FAIL t=%0t %s: got 0x%08h expected 0x%08h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    // address from block code and word offset
    function automatic apb_addr_t reg_addr(input blk_code_t blk, input reg_ofs_t ofs);
        apb_addr_t addr;
        addr = '0;
        addr[BLK_SEL_MSB:BLK_SEL_LSB] = blk;
        addr[OFS_MSB:OFS_LSB]         = ofs;
        return addr;
    endfunction

    // setup, access, then wait for pready_o; transfer must take 3 cycles
    task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic err);
        int cycles;
        cycles = 2;
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= write;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk_i);
        penable_i <= 1'b1;
        @(negedge clk_i);
        while (!pready_o && cycles < PREADY_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        rdata = prdata_o;
        err   = pslverr_o;
        if (!pready_o) begin
            $display("ERROR: no pready_o within %0d cycles at address 0x%08h", PREADY_LIMIT, addr);
            error_count++;
        end
        compare_value("transfer cycles", 32'(cycles), 32'd3);
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
        apb_data_t rdata;
        logic      err;
        apb_transfer(1'b1, addr, data, rdata, err);
        compare_value("pslverr_o", 32'(err), 32'(exp_err));
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, input logic exp_err);
        logic err;
        apb_transfer(1'b0, addr, '0, data, err);
        compare_value("pslverr_o", 32'(err), 32'(exp_err));
    endtask

    task automatic count_to_event(input int bit_pos, input int limit, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!fc_events_o[bit_pos] && cycles < limit);
    endtask

    // one-cycle pulse on the external event inputs
    task automatic pulse_sources(input logic dma, input logic pf, input fc_events_t expected);
        @(posedge clk_i);
        dma_pe_evt_i <= dma;
        pf_evt_i     <= pf;
        @(negedge clk_i);
        compare_value("fc_events_o before pulse", fc_events_o, '0);
        @(posedge clk_i);
        dma_pe_evt_i <= 1'b0;
        pf_evt_i     <= 1'b0;
        @(negedge clk_i);
        compare_value("fc_events_o on pulse", fc_events_o, expected);
        @(negedge clk_i);
        compare_value("fc_events_o after pulse", fc_events_o, '0);
    endtask

    task automatic slow_edge(input logic level, input logic expect_pulse);
        int pulses;
        int first;
        pulses = 0;
        first  = 0;
        @(posedge clk_i);
        slow_clk_i <= level;
        for (int n = 1; n <= 8; n++) begin
            @(negedge clk_i);
            if (fc_events_o[FC_EV_REF_EDGE]) begin
                pulses++;
                if (first == 0) begin
                    first = n;
                end
            end
            compare_value("fc_events_o other bits",
                          fc_events_o & ~(32'h1 << FC_EV_REF_EDGE), '0);
        end
        if (expect_pulse) begin
            compare_value("ref edge pulses", 32'(pulses), 32'd1);
            compare_value("ref edge latency in 3..4", 32'(first >= 3 && first <= 4), 32'd1);
        end else begin
            compare_value("masked ref edge pulses", 32'(pulses), 32'd0);
        end
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////
    task automatic test_readback();
        apb_data_t rdata;
        cmp_val  = $random(seed);
        load_val = $random(seed);
        mask_val = $random(seed);
        apb_write(reg_addr(BLK_TIMER, TMR_CMP), cmp_val, 1'b0);
        apb_write(reg_addr(BLK_WDT, WDT_LOAD), load_val, 1'b0);
        apb_write(reg_addr(BLK_EVENT, EVT_MASK), mask_val, 1'b0);
        apb_read(reg_addr(BLK_TIMER, TMR_CMP), rdata, 1'b0);
        compare_value("TMR_CMP", rdata, cmp_val);
        apb_read(reg_addr(BLK_WDT, WDT_LOAD), rdata, 1'b0);
        compare_value("WDT_LOAD", rdata, load_val);
        apb_read(reg_addr(BLK_EVENT, EVT_MASK), rdata, 1'b0);
        compare_value("EVT_MASK", rdata, mask_val);
    endtask

    task automatic test_unmapped();
        apb_data_t rdata;
        apb_read(32'h300, rdata, 1'b1);
        compare_value("prdata_o at 0x300", rdata, '0);
        apb_write(32'h300, $random(seed), 1'b1);
        // offset 2 would hit TMR_CTRL or WDT_KICK if the block were ignored
        // low bits forced high so a stray TMR_CTRL write shows up
        apb_write(32'h308, $random(seed) | 32'h3, 1'b1);
        apb_read(reg_addr(BLK_TIMER, TMR_CMP), rdata, 1'b0);
        compare_value("TMR_CMP after unmapped write", rdata, cmp_val);
        apb_read(reg_addr(BLK_TIMER, TMR_CTRL), rdata, 1'b0);
        compare_value("TMR_CTRL after unmapped write", rdata, '0);
        apb_read(reg_addr(BLK_WDT, WDT_LOAD), rdata, 1'b0);
        compare_value("WDT_LOAD after unmapped write", rdata, load_val);
        apb_read(reg_addr(BLK_WDT, WDT_COUNT), rdata, 1'b0);
        compare_value("WDT_COUNT after unmapped write", rdata, '0);
        apb_read(reg_addr(BLK_EVENT, EVT_MASK), rdata, 1'b0);
        compare_value("EVT_MASK after unmapped write", rdata, mask_val);
    endtask

    task automatic test_timer_period();
        int cycles;
        apb_write(reg_addr(BLK_EVENT, EVT_MASK), 32'h1 << FC_EV_TIMER_LO, 1'b0);
        apb_write(reg_addr(BLK_TIMER, TMR_CNT), '0, 1'b0);
        apb_write(reg_addr(BLK_TIMER, TMR_CMP), 32'd20, 1'b0);
        apb_write(reg_addr(BLK_TIMER, TMR_CTRL), 32'd3, 1'b0);
        count_to_event(FC_EV_TIMER_LO, 64, cycles);
        if (!fc_events_o[FC_EV_TIMER_LO]) begin
            $display("ERROR: timer event never appeared on fc_events_o");
            error_count++;
        end else begin
            // clear on match gives a period of CMP + 1
            repeat (2) begin
                count_to_event(FC_EV_TIMER_LO, 40, cycles);
                compare_value("timer pulse spacing", 32'(cycles), 32'd21);
            end
        end
        apb_write(reg_addr(BLK_TIMER, TMR_CTRL), '0, 1'b0);
    endtask

    task automatic test_event_mask();
        fc_events_t all_ext;
        all_ext = (32'h1 << FC_EV_DMA_PE) | (32'h1 << FC_EV_PF) | (32'h1 << FC_EV_REF_EDGE);
        apb_write(reg_addr(BLK_EVENT, EVT_MASK), '0, 1'b0);
        pulse_sources(1'b1, 1'b0, '0);
        pulse_sources(1'b0, 1'b1, '0);
        apb_write(reg_addr(BLK_EVENT, EVT_MASK), all_ext, 1'b0);
        pulse_sources(1'b1, 1'b0, 32'h1 << FC_EV_DMA_PE);
        pulse_sources(1'b0, 1'b1, 32'h1 << FC_EV_PF);
        pulse_sources(1'b1, 1'b1, (32'h1 << FC_EV_DMA_PE) | (32'h1 << FC_EV_PF));
        apb_write(reg_addr(BLK_EVENT, EVT_MASK), 32'h1 << FC_EV_PF, 1'b0);
        pulse_sources(1'b1, 1'b1, 32'h1 << FC_EV_PF);
        // both edges of the slow clock count
        apb_write(reg_addr(BLK_EVENT, EVT_MASK), all_ext, 1'b0);
        slow_edge(1'b1, 1'b1);
        slow_edge(1'b0, 1'b1);
        apb_write(reg_addr(BLK_EVENT, EVT_MASK), 32'h1 << FC_EV_DMA_PE, 1'b0);
        slow_edge(1'b1, 1'b0);
    endtask

    task automatic test_watchdog();
        apb_data_t rdata;
        int        cycles;
        apb_write(reg_addr(BLK_WDT, WDT_LOAD), 32'd30, 1'b0);
        apb_write(reg_addr(BLK_WDT, WDT_CTRL), 32'd1, 1'b0);
        // a kick transfer plus 17 idle cycles is one reload every 20 cycles
        repeat (4) begin
            repeat (17) begin
                @(negedge clk_i);
                compare_value("wdt_reset_o while kicked", 32'(wdt_reset_o), 32'd0);
            end
            apb_write(reg_addr(BLK_WDT, WDT_KICK), 32'd1, 1'b0);
        end
        cycles = 0;
        while (!wdt_reset_o && cycles < 40) begin
            @(negedge clk_i);
            cycles++;
        end
        compare_value("wdt_reset_o after kicks stop", 32'(wdt_reset_o), 32'd1);
        compare_value("wdt expiry within 32 cycles", 32'(cycles <= 32), 32'd1);
        apb_read(reg_addr(BLK_WDT, WDT_COUNT), rdata, 1'b0);
        compare_value("WDT_COUNT after expiry", rdata, '0);
        compare_value("wdt_reset_o stays high", 32'(wdt_reset_o), 32'd1);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        seed         = 32'h5def;
        reset_i      = 1'b1;
        paddr_i      = '0;
        pwdata_i     = '0;
        pwrite_i     = 1'b0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        dma_pe_evt_i = 1'b0;
        pf_evt_i     = 1'b0;
        slow_clk_i   = 1'b0;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        compare_value("pready_o after reset", 32'(pready_o), 32'd0);
        compare_value("pslverr_o after reset", 32'(pslverr_o), 32'd0);
        compare_value("wdt_reset_o after reset", 32'(wdt_reset_o), 32'd0);
        compare_value("fc_events_o after reset", fc_events_o, '0);

        test_readback();
        test_unmapped();
        test_timer_period();
        test_event_mask();
        // runs last because the watchdog reset output stays high
        test_watchdog();

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
hw/soc_periph_pkg.sv
hw/apb_access_fsm.sv
hw/periph_decoder.sv
hw/timer_unit.sv
hw/wdt_unit.sv
hw/fc_event_map.sv
hw/soc_periph_top.sv
verification/tb_soc_periph.sv

// File: Makefile
# Verilator simulation of the APB peripheral subsystem

TOP := tb_soc_periph
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module $(TOP) -o $(TOP)

# the log decides pass or fail
run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
